/* core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Machine word and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address after reset or release
`define RESET_PC 32'h0000_0000

`define HALT_OPCODE 7'h7F // Custom stop opcode

`endif

/* isaPkg.sv */
`default_nettype none
`include "core_config.svh"

package isaPkg;

   typedef logic [`XLEN-1:0]       word_t;
   typedef logic [`REG_ADDR_W-1:0] regIdx_t;
   typedef logic [6:0]             opcode_t;

   // Base opcodes of the supported subset
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011; // Always treated as ORI
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;

   typedef enum logic [2:0] {
      NONE,
      ALU,
      LUI,
      LOAD,
      STORE,
      HALT
   } opClass_t;

   typedef enum logic [1:0] {
      ADD,
      SUB,
      SLL,
      OR
   } aluOp_t;

   typedef struct packed {
      opClass_t    opClass;
      aluOp_t      aluOp;
      regIdx_t     rd;
      regIdx_t     rs1;
      regIdx_t     rs2;
      logic        useImm;  // Second operand from imm
      logic [19:0] imm;     // I/S zero-extended, U raw
   } decodedOp_t;

endpackage

`default_nettype wire

/* busPkg.sv */
`default_nettype none

package busPkg;

   // Values of the write flag
   localparam logic BUS_READ  = 1'b0;
   localparam logic BUS_WRITE = 1'b1;

   // One request on the shared memory port, word addressed
   typedef struct packed {
      isaPkg::word_t addr;
      logic          write;
      isaPkg::word_t wdata;
   } memReq_t;

endpackage

`default_nettype wire

/* seqCtrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module seqCtrl (
   input  logic               clk,
   input  logic               rstn,
   input  logic               loadEn,
   input  logic               memVld,
   input  isaPkg::word_t      memRData,
   input  isaPkg::decodedOp_t op,
   input  isaPkg::word_t      aluResult,
   input  isaPkg::word_t      storeData,
   output logic               memReqValid,
   output busPkg::memReq_t    memReq,
   output isaPkg::word_t      inst,
   output logic               decodeStep,
   output logic               loadDone,
   output logic               halt
);
   import isaPkg::*;
   import busPkg::*;

   typedef enum logic [1:0] {
      HALTED,
      FETCH,
      DECODE,
      MEM
   } seqState_t;

   seqState_t state;
   word_t     pc;
   word_t     instReg;
   logic      isMemOp;

   assign isMemOp    = (op.opClass == LOAD) || (op.opClass == STORE);
   assign inst       = instReg;
   assign decodeStep = (state == DECODE);
   assign loadDone   = (state == MEM) && memVld && (memReq.write == BUS_READ);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state       <= HALTED;
         halt        <= 1'b1;
         memReqValid <= 1'b0;
         pc          <= `RESET_PC;
      end else begin
         case (state)
            HALTED: begin
               if (loadEn) begin
                  state <= FETCH;
                  halt  <= 1'b0;
               end
            end
            FETCH: begin
               if (!memReqValid) begin
                  memReqValid <= 1'b1;
               end else if (memVld) begin
                  memReqValid <= 1'b0;
                  pc          <= pc + 1'b1; // Word addressed PC
                  state       <= DECODE;
               end
            end
            DECODE: begin
               if (op.opClass == HALT) begin
                  halt  <= 1'b1;
                  state <= HALTED;
               end else if (isMemOp) begin
                  memReqValid <= 1'b1; // Fetch stalls during data access
                  state       <= MEM;
               end else begin
                  state <= FETCH;
               end
            end
            MEM: begin
               if (memVld) begin
                  memReqValid <= 1'b0;
                  state       <= FETCH;
               end
            end
            default: state <= HALTED;
         endcase
      end
   end

   // Request payload and instruction register
   always_ff @(posedge clk) begin
      if (state == FETCH && !memReqValid) begin
         memReq.addr  <= pc;
         memReq.write <= BUS_READ;
         memReq.wdata <= '0;
      end else if (state == DECODE && isMemOp) begin
         memReq.addr  <= aluResult;
         memReq.write <= (op.opClass == STORE) ? BUS_WRITE : BUS_READ;
         memReq.wdata <= storeData;
      end
      if (state == FETCH && memReqValid && memVld) begin
         instReg <= memRData;
      end
   end

   pReqNotHalted: assert property (@(posedge clk) disable iff (!rstn)
      $rose(memReqValid) |-> !halt)
      else $error("seqCtrl: memory request raised while halted");

   pReqStable: assert property (@(posedge clk) disable iff (!rstn)
      memReqValid && !memVld |=> memReqValid && $stable(memReq))
      else $error("seqCtrl: memory request changed before memVld");

endmodule

`default_nettype wire

/* decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module decoder (
   input  isaPkg::word_t      inst,
   output isaPkg::decodedOp_t op
);
   import isaPkg::*;

   opcode_t    opcode;
   logic [6:0] funct7;
   logic [2:0] funct3;

   assign opcode = inst[6:0];
   assign funct7 = inst[31:25];
   assign funct3 = inst[14:12];

   always_comb begin
      op = '0;
      case (opcode)
         OPC_LUI: begin
            op.opClass = LUI;
            op.rd      = inst[11:7];
            op.imm     = inst[31:12];
         end
         OPC_OP_IMM: begin
            op.opClass = ALU;
            op.aluOp   = OR;
            op.useImm  = 1'b1;
            op.rd      = inst[11:7];
            op.rs1     = inst[19:15];
            op.imm     = {8'h00, inst[31:20]};
         end
         OPC_OP: begin
            op.opClass = ALU;
            op.rd      = inst[11:7];
            op.rs1     = inst[19:15];
            op.rs2     = inst[24:20];
            if (funct7 == 7'b0100000) begin
               op.aluOp = SUB;
            end else if (funct7 == 7'b0000000 && funct3 == 3'b001) begin
               op.aluOp = SLL;
            end else begin
               op.aluOp = ADD; // Unrecognized patterns add
            end
         end
         OPC_LOAD: begin
            op.opClass = LOAD; // Any width loads a full word
            op.aluOp   = ADD;
            op.useImm  = 1'b1;
            op.rd      = inst[11:7];
            op.rs1     = inst[19:15];
            op.imm     = {8'h00, inst[31:20]};
         end
         OPC_STORE: begin
            op.opClass = STORE;
            op.aluOp   = ADD;
            op.useImm  = 1'b1;
            op.rs1     = inst[19:15];
            op.rs2     = inst[24:20];
            op.imm     = {8'h00, inst[31:25], inst[11:7]};
         end
         `HALT_OPCODE: op.opClass = HALT;
         default: op.opClass = NONE;
      endcase
   end

   always_comb begin
      if (!$isunknown(inst)) begin
         assert final (!$isunknown(op.opClass))
            else $error("decoder: unknown opClass for inst %h", inst);
      end
   end

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
   input  logic               clk,
   input  logic               rstn,
   input  isaPkg::decodedOp_t op,
   input  logic               decodeStep,
   input  logic               loadDone,
   input  isaPkg::word_t      memRData,
   input  isaPkg::word_t      rdata1,
   input  isaPkg::word_t      rdata2,
   output isaPkg::regIdx_t    rs1,
   output isaPkg::regIdx_t    rs2,
   output isaPkg::word_t      aluResult,
   output isaPkg::word_t      storeData,
   output logic               wrEn,
   output isaPkg::regIdx_t    wrIdx,
   output isaPkg::word_t      wrData
);
   import isaPkg::*;

   word_t operandB;
   word_t luiValue;
   logic  regWrite;

   assign rs1       = op.rs1;
   assign rs2       = op.rs2;
   assign storeData = rdata2;

   assign operandB = op.useImm ? word_t'(op.imm) : rdata2;
   assign luiValue = word_t'({op.imm, 12'h000});

   // Effective address for loads and stores too
   always_comb begin
      case (op.aluOp)
         ADD:     aluResult = rdata1 + operandB;
         SUB:     aluResult = rdata1 - operandB;
         SLL:     aluResult = rdata1 << operandB[4:0];
         OR:      aluResult = rdata1 | operandB;
         default: aluResult = '0;
      endcase
   end

   assign regWrite = decodeStep && (op.opClass == ALU || op.opClass == LUI);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wrEn <= 1'b0;
      end else begin
         wrEn <= regWrite || loadDone;
      end
   end

   // Load rd is still in the instruction register at loadDone
   always_ff @(posedge clk) begin
      if (regWrite || loadDone) begin
         wrIdx <= op.rd;
         if (loadDone) begin
            wrData <= memRData;
         end else if (op.opClass == LUI) begin
            wrData <= luiValue;
         end else begin
            wrData <= aluResult;
         end
      end
   end

   // Each write has exactly one cause
   pWrCause: assert property (@(posedge clk) disable iff (!rstn)
      wrEn |-> $past(decodeStep ^ loadDone))
      else $error("execUnit: register write without a single decode or load");

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module regFile (
   input  logic            clk,
   input  logic            rstn,
   input  isaPkg::regIdx_t rs1,
   input  isaPkg::regIdx_t rs2,
   output isaPkg::word_t   rdata1,
   output isaPkg::word_t   rdata2,
   input  logic            wrEn,
   input  isaPkg::regIdx_t wrIdx,
   input  isaPkg::word_t   wrData
);
   import isaPkg::*;

   word_t regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrIdx != '0) begin
         regs[wrIdx] <= wrData; // x0 never written
      end
   end

   assign rdata1 = regs[rs1];
   assign rdata2 = regs[rs2];

   pZeroReg: assert property (@(posedge clk) disable iff (!rstn)
      (rs1 == '0 |-> rdata1 == '0) and (rs2 == '0 |-> rdata2 == '0))
      else $error("regFile: x0 read back nonzero");

endmodule

`default_nettype wire

/* coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop (
   input  logic            clk,
   input  logic            rstn,
   input  logic            loadEn,
   input  logic            memVld,
   input  isaPkg::word_t   memRData,
   output logic            memReqValid,
   output busPkg::memReq_t memReq,
   output logic            halt
);
   import isaPkg::*;

   word_t      inst;
   decodedOp_t op;
   logic       decodeStep;
   logic       loadDone;
   word_t      aluResult;
   word_t      storeData;
   regIdx_t    rs1;
   regIdx_t    rs2;
   word_t      rdata1;
   word_t      rdata2;
   logic       wrEn;
   regIdx_t    wrIdx;
   word_t      wrData;

   seqCtrl u_seqCtrl (
      .clk         (clk),
      .rstn        (rstn),
      .loadEn      (loadEn),
      .memVld      (memVld),
      .memRData    (memRData),
      .op          (op),
      .aluResult   (aluResult),
      .storeData   (storeData),
      .memReqValid (memReqValid),
      .memReq      (memReq),
      .inst        (inst),
      .decodeStep  (decodeStep),
      .loadDone    (loadDone),
      .halt        (halt)
   );

   decoder u_decoder (
      .inst (inst),
      .op   (op)
   );

   execUnit u_execUnit (
      .clk        (clk),
      .rstn       (rstn),
      .op         (op),
      .decodeStep (decodeStep),
      .loadDone   (loadDone),
      .memRData   (memRData),
      .rdata1     (rdata1),
      .rdata2     (rdata2),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluResult  (aluResult),
      .storeData  (storeData),
      .wrEn       (wrEn),
      .wrIdx      (wrIdx),
      .wrData     (wrData)
   );

   regFile u_regFile (
      .clk    (clk),
      .rstn   (rstn),
      .rs1    (rs1),
      .rs2    (rs2),
      .rdata1 (rdata1),
      .rdata2 (rdata2),
      .wrEn   (wrEn),
      .wrIdx  (wrIdx),
      .wrData (wrData)
   );

endmodule

`default_nettype wire

/* tbCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module tbCore;
   import isaPkg::*;
   import busPkg::*;

   localparam int MAX_RECORDS = 64;

   logic       clk;
   logic       rstn;
   logic       loadEn;
   logic       memVld = 1'b0;
   word_t      memRData = '0;
   logic       memReqValid;
   memReq_t    memReq;
   logic       halt;

   word_t      mem [word_t]; // Sparse word memory
   word_t      recs [0:3*MAX_RECORDS-1];
   word_t      expAddr [$];
   word_t      expData [$];
   int         expTest [$];
   int         progWords;
   logic       memLoaded = 1'b0;
   integer     seed = 32'h0b6d38fb;
   int         errCount [1:5];
   memReq_t    req;
   logic       pending = 1'b0;
   logic [1:0] delay;
   logic       dataNext = 1'b0;
   logic       expectWrite = 1'b0;
   word_t      modelPc = `RESET_PC;
   int         reqCount;
   int         fetchCount;
   int         haltReqCount;
   int         failedTests;
   int         totalErrors;

   coreTop u_coreTop (
      .clk         (clk),
      .rstn        (rstn),
      .loadEn      (loadEn),
      .memVld      (memVld),
      .memRData    (memRData),
      .memReqValid (memReqValid),
      .memReq      (memReq),
      .halt        (halt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t readWord(input word_t a);
      return mem.exists(a) ? mem[a] : '0;
   endfunction

   task automatic loadProgram();
      word_t kind;
      int    i;
      for (i = 0; i < 3*MAX_RECORDS; i++) begin
         recs[i] = '0;
      end
      $readmemh("prog_input.txt", recs);
      for (i = 0; i < MAX_RECORDS; i++) begin
         kind = recs[3*i];
         if (kind == 1 || kind == 2) begin
            mem[recs[3*i+1]] = recs[3*i+2];
            progWords += (kind == 1) ? 1 : 0;
         end else if (kind == 3 || kind == 4) begin
            expAddr.push_back(recs[3*i+1]);
            expData.push_back(recs[3*i+2]);
            expTest.push_back(int'(kind));
         end
      end
   endtask

   task automatic reportMismatch(input int test, input string name,
                                 input word_t exp, input word_t act);
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
      errCount[test]++;
   endtask

   task automatic reportFailure(input int test, input string msg);
      $display("error at time %0t: %s", $time, msg);
      errCount[test]++;
   endtask

   task automatic reportTest(input int test, input string name);
      if (errCount[test] == 0) begin
         $display("test %0d %s: passed", test, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", test, name, errCount[test]);
      end
   endtask

   task automatic compareStore(input memReq_t r);
      word_t ea;
      word_t ed;
      int    t;
      if (expAddr.size() == 0) begin
         reportFailure(3, "store request with no expected store left");
      end else begin
         ea = expAddr.pop_front();
         ed = expData.pop_front();
         t  = expTest.pop_front();
         if (r.addr !== ea) begin
            reportMismatch(t, "memReq.addr", ea, r.addr);
         end
         if (r.wdata !== ed) begin
            reportMismatch(t, "memReq.wdata", ed, r.wdata);
         end
      end
   endtask

   task automatic checkRequest(input memReq_t r);
      word_t fetched;
      reqCount++;
      if (reqCount == 1) begin
         if (r.addr !== `RESET_PC) begin
            reportMismatch(1, "memReq.addr", `RESET_PC, r.addr);
         end
         if (r.write !== BUS_READ) begin
            reportMismatch(1, "memReq.write", BUS_READ, r.write);
         end
      end
      if (dataNext) begin
         dataNext = 1'b0; // Data phase of the last load or store
         if (r.write !== expectWrite) begin
            reportFailure(expectWrite ? 3 : 4, "data access went the wrong direction");
         end else if (r.write) begin
            compareStore(r);
         end
      end else begin
         if (r.write !== BUS_READ) begin
            reportFailure(2, "write request where an instruction fetch was due");
         end
         if (r.addr !== modelPc) begin
            reportMismatch(2, "memReq.addr", modelPc, r.addr);
         end
         fetched     = readWord(modelPc);
         dataNext    = (fetched[6:0] == OPC_LOAD) || (fetched[6:0] == OPC_STORE);
         expectWrite = (fetched[6:0] == OPC_STORE);
         modelPc++;
         fetchCount++;
      end
   endtask

   // Memory model, answers 1 to 4 cycles after the request
   always @(posedge clk) begin
      if (!rstn) begin
         memVld  <= 1'b0;
         pending <= 1'b0;
      end else if (memVld) begin
         memVld  <= 1'b0; // Core drops its request at this edge
         pending <= 1'b0;
      end else if (pending) begin
         if (delay == 0) begin
            if (req.write) begin
               mem[req.addr] = req.wdata;
            end else begin
               memRData <= readWord(req.addr);
            end
            memVld <= 1'b1;
         end else begin
            delay <= delay - 1'b1;
         end
      end else if (memReqValid) begin
         req     <= memReq;
         pending <= 1'b1;
         delay   <= 2'($random(seed));
         checkRequest(memReq);
      end
   end

   initial begin : watchdog
      wait (memLoaded);
      repeat (60 * progWords + 100) @(posedge clk);
      $display("timeout: the core did not halt within %0d cycles", 60 * progWords + 100);
      $display("Done: errors found");
      $finish;
   end

   initial begin : main
      rstn   = 1'b0;
      loadEn = 1'b0;
      loadProgram();
      memLoaded = 1'b1;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;

      // Core must stay idle until released
      repeat (5) begin
         @(posedge clk);
         if (halt !== 1'b1) begin
            reportMismatch(1, "halt", 32'd1, word_t'(halt));
         end
         if (memReqValid !== 1'b0) begin
            reportMismatch(1, "memReqValid", 32'd0, word_t'(memReqValid));
         end
      end
      @(posedge clk);
      loadEn <= 1'b1;
      @(posedge clk);
      loadEn <= 1'b0;
      while (reqCount == 0) @(posedge clk);
      reportTest(1, "reset and release");

      while (halt !== 1'b1) @(posedge clk);
      if (fetchCount != progWords) begin
         reportMismatch(2, "fetch count", progWords, fetchCount);
      end
      reportTest(2, "sequential fetch");
      reportTest(3, "arithmetic, LUI and OR-immediate stores");
      reportTest(4, "loads");

      haltReqCount = reqCount;
      repeat (20) begin
         @(posedge clk);
         if (memReqValid !== 1'b0) begin
            reportFailure(5, "memory request raised after halt");
         end
      end
      if (reqCount != haltReqCount) begin
         reportFailure(5, "memory request accepted after halt");
      end
      if (expAddr.size() != 0) begin
         reportFailure(5, $sformatf("%0d expected stores never seen", expAddr.size()));
      end
      reportTest(5, "halt");

      failedTests = 0;
      totalErrors = 0;
      foreach (errCount[i]) begin
         totalErrors += errCount[i];
         failedTests += (errCount[i] != 0) ? 1 : 0;
      end
      $display("summary: 5 tests, %0d failed, %0d errors", failedTests, totalErrors);
      if (totalErrors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* prog_input.txt */
// kind address value, all hex: kind 1 program word, 2 data word,
// 3 expected store of an ALU or LUI result, 4 expected store of a loaded word
1 00000000 123450b7 // lui  x1, 0x12345
1 00000001 6780e113 // ori  x2, x1, 0x678
1 00000002 00506193 // ori  x3, x0, 5
1 00000003 00310233 // add  x4, x2, x3
1 00000004 403102b3 // sub  x5, x2, x3
1 00000005 00319333 // sll  x6, x3, x3
1 00000006 abcde037 // lui  x0, 0xabcde
1 00000007 10102023 // sw   x1, 0x100(x0)
1 00000008 102020a3 // sw   x2, 0x101(x0)
1 00000009 10302123 // sw   x3, 0x102(x0)
1 0000000a 104021a3 // sw   x4, 0x103(x0)
1 0000000b 10502223 // sw   x5, 0x104(x0)
1 0000000c 106022a3 // sw   x6, 0x105(x0)
1 0000000d 10002323 // sw   x0, 0x106(x0)
1 0000000e 08002383 // lw   x7, 0x80(x0)
1 0000000f 07d1a403 // lw   x8, 0x7d(x3)
1 00000010 107023a3 // sw   x7, 0x107(x0)
1 00000011 10802423 // sw   x8, 0x108(x0)
1 00000012 0000007f // halt
2 00000080 cafef00d
2 00000082 0badbeef
3 00000100 12345000
3 00000101 12345678
3 00000102 00000005
3 00000103 1234567d
3 00000104 12345673
3 00000105 000000a0
3 00000106 00000000 // x0 stays zero
4 00000107 cafef00d
4 00000108 0badbeef

/* flist.f */
+incdir+.
isaPkg.sv
busPkg.sv
seqCtrl.sv
decoder.sv
execUnit.sv
regFile.sv
coreTop.sv
tbCore.sv

/* Bender.yml */
package:
  name: rv32_subset_core

export_include_dirs:
  - .

sources:
  - isaPkg.sv
  - busPkg.sv
  - seqCtrl.sv
  - decoder.sv
  - execUnit.sv
  - regFile.sv
  - coreTop.sv
  - target: test
    files:
      - tbCore.sv
